// File: hw/adc_capture_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC capture constants
// buffer depth, trigger window and slope, timeout, reset threshold
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ADC_CAPTURE_SETTINGS_SVH
`define ADC_CAPTURE_SETTINGS_SVH

// samples stored per capture
`define ADC_SAMPLE_DEPTH 400

// armed sample ticks before giving up on a trigger
`define ADC_TRIG_TIMEOUT 400

// trigger window around the threshold with both ends inclusive
`define ADC_TRIG_WIN_LO 40
`define ADC_TRIG_WIN_HI 60

// minimum rise over the previous sample
`define ADC_TRIG_SLOPE 50

`define ADC_THRESH_RESET 2000

`endif

// File: hw/adc_capture_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC capture types
// sample, buffer index, bus regions and capture configuration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "adc_capture_settings.svh"

package adc_capture_pkg;

    // one ADC conversion result
    typedef logic [11:0] sample_t;

    // index into the sample buffer
    typedef logic [$clog2(`ADC_SAMPLE_DEPTH)-1:0] buf_addr_t;

    // bus region taken from module_in[15:13]
    typedef enum logic [2:0] {
        REG_BUF_READ = 3'd0,
        REG_START    = 3'd1,
        REG_DIV_INT  = 3'd2,
        REG_DIV_FRAC = 3'd3,
        REG_THRESH   = 3'd4
    } reg_region_e;

    // host programmed settings in 44 bits
    typedef struct packed {
        logic [15:0] div_int;
        logic [7:0]  div_num;
        logic [7:0]  div_den;
        sample_t     threshold;
    } capture_cfg_t;

endpackage

// File: hw/frac_clock_divider.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fractional-N clock divider
// builds the ADC clock and a one-clock tick on each of its rises
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module frac_clock_divider
    import adc_capture_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  capture_cfg_t cfg,
    output logic         adc_clk,
    output logic         sample_tick
);

    logic        cfg_ok;
    logic        running;
    logic        at_boundary;
    logic        carry;
    logic [8:0]  acc_sum;
    logic [7:0]  acc;
    logic [16:0] cnt;
    logic [16:0] period_len;
    logic [16:0] next_len;

    assign cfg_ok = (cfg.div_int >= 16'd2) && (cfg.div_num < cfg.div_den);
    assign at_boundary = !running || (cnt == period_len - 17'd1);

    always_comb begin
        // a phase left over from a larger denominator restarts at zero
        if (acc < cfg.div_den) begin
            acc_sum = {1'b0, acc} + {1'b0, cfg.div_num};
        end else begin
            acc_sum = {1'b0, cfg.div_num};
        end
        carry = acc_sum >= {1'b0, cfg.div_den};
        next_len = {1'b0, cfg.div_int} + {16'd0, carry};
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            running     <= 1'b0;
            cnt         <= '0;
            period_len  <= '0;
            acc         <= '0;
            adc_clk     <= 1'b0;
            sample_tick <= 1'b0;
        end else if (at_boundary) begin
            running     <= cfg_ok;
            cnt         <= '0;
            period_len  <= next_len;
            acc         <= carry ? 8'(acc_sum - {1'b0, cfg.div_den}) : acc_sum[7:0];
            adc_clk     <= cfg_ok;
            sample_tick <= cfg_ok;
        end else begin
            cnt         <= cnt + 17'd1;
            // high for the first half rounded down
            adc_clk     <= (cnt + 17'd1) < (period_len >> 1);
            sample_tick <= 1'b0;
        end
    end

    a_tick_on_rise: assert property (@(posedge clk) disable iff (!reset)
        sample_tick |-> adc_clk && !$past(adc_clk));

endmodule

// File: hw/capture_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host bus decoder
// configuration registers, capture start and buffer readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "adc_capture_settings.svh"

module capture_regs
    import adc_capture_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         en,
    input  logic [15:0]  module_in,
    input  sample_t      rd_data,
    output logic [15:0]  module_out,
    output buf_addr_t    rd_addr,
    output logic         rd_en,
    output logic         start,
    output capture_cfg_t cfg
);

    logic        en_d;
    logic        en_rise;
    logic        en_fall;
    logic        rd_valid;
    reg_region_e rise_region;
    reg_region_e region;

    assign en_rise = en & ~en_d;
    assign en_fall = ~en & en_d;
    assign rise_region = reg_region_e'(module_in[15:13]);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            en_d     <= 1'b0;
            region   <= REG_BUF_READ;
            start    <= 1'b0;
            rd_en    <= 1'b0;
            rd_valid <= 1'b0;
            cfg      <= '{div_int: '0, div_num: '0, div_den: '0,
                          threshold: sample_t'(`ADC_THRESH_RESET)};
        end else begin
            en_d     <= en;
            start    <= en_rise && (rise_region == REG_START);
            rd_en    <= en_rise && (rise_region == REG_BUF_READ);
            rd_valid <= rd_en;
            if (en_rise) begin
                region <= rise_region;
            end
            // writes complete on the falling edge of en
            if (en_fall) begin
                case (region)
                    REG_DIV_INT: cfg.div_int <= module_in;
                    REG_DIV_FRAC: begin
                        cfg.div_num <= module_in[7:0];
                        cfg.div_den <= module_in[15:8];
                    end
                    REG_THRESH: cfg.threshold <= module_in[11:0];
                    default: ;
                endcase
            end
        end
    end

    // read address on the rise, data two clocks later
    always_ff @(posedge clk) begin
        if (en_rise) begin
            rd_addr <= buf_addr_t'(module_in[8:0]);
        end
        if (rd_valid) begin
            module_out <= {4'd0, rd_data};
        end
    end

    a_start_pulse: assert property (@(posedge clk) disable iff (!reset)
        start |=> !start);

endmodule

// File: hw/trigger_detect.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trigger detector
// window and slope test on armed samples, with a timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "adc_capture_settings.svh"

module trigger_detect
    import adc_capture_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  capture_cfg_t cfg,
    input  logic         arm,
    input  logic         sample_tick,
    input  sample_t      adc_data,
    output logic         trig_hit,
    output logic         trig_timeout
);

    localparam int CNT_W = $clog2(`ADC_TRIG_TIMEOUT + 1);

    sample_t          prev_sample;
    logic [CNT_W-1:0] tick_cnt;
    logic             in_window;
    logic             steep;

    // 13-bit compares so the window never wraps
    always_comb begin
        in_window = ({1'b0, adc_data} + 13'(`ADC_TRIG_WIN_LO) >= {1'b0, cfg.threshold})
                 && ({1'b0, adc_data} <= {1'b0, cfg.threshold} + 13'(`ADC_TRIG_WIN_HI));
        steep = {1'b0, adc_data} > {1'b0, prev_sample} + 13'(`ADC_TRIG_SLOPE);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            prev_sample  <= '0;
            tick_cnt     <= '0;
            trig_hit     <= 1'b0;
            trig_timeout <= 1'b0;
        end else if (!arm) begin
            // previous sample reads as zero on the first armed tick
            prev_sample  <= '0;
            tick_cnt     <= '0;
            trig_hit     <= 1'b0;
            trig_timeout <= 1'b0;
        end else begin
            trig_hit     <= 1'b0;
            trig_timeout <= 1'b0;
            if (sample_tick) begin
                prev_sample <= adc_data;
                tick_cnt    <= tick_cnt + 1'b1;
                if (in_window && steep) begin
                    trig_hit <= 1'b1;
                end else if (tick_cnt == CNT_W'(`ADC_TRIG_TIMEOUT - 1)) begin
                    trig_timeout <= 1'b1;
                end
            end
        end
    end

    a_hit_xor_timeout: assert property (@(posedge clk) disable iff (!reset)
        !(trig_hit && trig_timeout));

endmodule

// File: hw/capture_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// capture sequencer
// arms the trigger, fills the buffer and drives the host status lines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "adc_capture_settings.svh"

module capture_sequencer
    import adc_capture_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  logic      sample_tick,
    input  logic      trig_hit,
    input  logic      trig_timeout,
    output logic      arm,
    output logic      wr_en,
    output buf_addr_t wr_addr,
    output logic      notify,
    output logic      adc_oe,
    output logic      read_adc_result
);

    localparam buf_addr_t LAST_ADDR = buf_addr_t'(`ADC_SAMPLE_DEPTH - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_TRIG,
        S_SAMPLE,
        S_FINISH
    } seq_state_e;

    typedef struct packed {
        logic busy;
        logic ok;
    } capture_status_t;

    seq_state_e      state;
    capture_status_t status;

    assign arm             = (state == S_WAIT_TRIG);
    assign wr_en           = (state == S_SAMPLE) && sample_tick;
    assign notify          = status.busy;
    // active low ADC output enable stays on for the whole capture
    assign adc_oe          = ~status.busy;
    assign read_adc_result = status.ok;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state   <= S_IDLE;
            status  <= '0;
            wr_addr <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= S_WAIT_TRIG;
                        status  <= '{busy: 1'b1, ok: 1'b1};
                        wr_addr <= '0;
                    end
                end
                S_WAIT_TRIG: begin
                    if (trig_hit) begin
                        state <= S_SAMPLE;
                    end else if (trig_timeout) begin
                        // keep capturing, but mark it untriggered
                        state     <= S_SAMPLE;
                        status.ok <= 1'b0;
                    end
                end
                S_SAMPLE: begin
                    if (wr_en) begin
                        if (wr_addr == LAST_ADDR) begin
                            state   <= S_FINISH;
                            wr_addr <= '0;
                        end else begin
                            wr_addr <= wr_addr + 1'b1;
                        end
                    end
                end
                default: begin
                    state       <= S_IDLE;
                    status.busy <= 1'b0;
                end
            endcase
        end
    end

    a_idle_quiet: assert property (@(posedge clk) disable iff (!reset)
        (state == S_IDLE) |-> !notify);

    a_addr_range: assert property (@(posedge clk) disable iff (!reset)
        wr_addr < buf_addr_t'(`ADC_SAMPLE_DEPTH));

endmodule

// File: hw/sample_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample buffer
// one write port, one registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "adc_capture_settings.svh"

module sample_buffer
    import adc_capture_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  buf_addr_t wr_addr,
    input  sample_t   wr_data,
    input  logic      rd_en,
    input  buf_addr_t rd_addr,
    output sample_t   rd_data
);

    sample_t mem [`ADC_SAMPLE_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hw/frequency_measure.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC capture top level
// host strobe bus, sample clock divider, trigger and 400-sample buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module frequency_measure
    import adc_capture_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        en,
    input  logic [15:0] module_in,
    output logic [15:0] module_out,
    output logic        notify,
    output logic        read_adc_result,
    input  logic [11:0] adc_data,
    output logic        adc_clk,
    output logic        adc_oe
);

    capture_cfg_t cfg;
    sample_t      rd_data;
    buf_addr_t    rd_addr;
    buf_addr_t    wr_addr;
    logic         rd_en;
    logic         wr_en;
    logic         start;
    logic         sample_tick;
    logic         arm;
    logic         trig_hit;
    logic         trig_timeout;

    capture_regs u_regs (
        .clk(clk), .reset(reset), .en(en), .module_in(module_in), .rd_data(rd_data),
        .module_out(module_out), .rd_addr(rd_addr), .rd_en(rd_en), .start(start), .cfg(cfg)
    );

    frac_clock_divider u_divider (
        .clk(clk), .reset(reset), .cfg(cfg), .adc_clk(adc_clk), .sample_tick(sample_tick)
    );

    trigger_detect u_trigger (
        .clk(clk), .reset(reset), .cfg(cfg), .arm(arm), .sample_tick(sample_tick),
        .adc_data(adc_data), .trig_hit(trig_hit), .trig_timeout(trig_timeout)
    );

    capture_sequencer u_sequencer (
        .clk(clk), .reset(reset), .start(start), .sample_tick(sample_tick),
        .trig_hit(trig_hit), .trig_timeout(trig_timeout), .arm(arm), .wr_en(wr_en),
        .wr_addr(wr_addr), .notify(notify), .adc_oe(adc_oe), .read_adc_result(read_adc_result)
    );

    sample_buffer u_buffer (
        .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(adc_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

// File: dv/tb_frequency_measure.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC capture testbench
// random ramp ADC model, divider period checks and capture readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "adc_capture_settings.svh"

module tb_frequency_measure
    import adc_capture_pkg::*;
();

    localparam int DIV_TESTS = 6;
    localparam int CAPTURES  = 3;
    // worst case N = 9 with 810 ticks and 400 five-clock reads per capture
    localparam int CYCLE_LIMIT = CAPTURES * (810 * 10 + 5 * `ADC_SAMPLE_DEPTH)
                               + DIV_TESTS * 20 * 10 + 2000;

    logic        clk;
    logic        reset;
    logic        en;
    logic [15:0] module_in;
    logic [15:0] module_out;
    logic        notify;
    logic        read_adc_result;
    logic [11:0] adc_data;
    logic        adc_clk;
    logic        adc_oe;

    int      cyc = 0;
    int      fall_cyc = 0;
    int      ramp = 0;
    int      tick_cyc[$];
    sample_t tick_val[$];

    frequency_measure uut (
        .clk(clk), .reset(reset), .en(en), .module_in(module_in), .module_out(module_out),
        .notify(notify), .read_adc_result(read_adc_result), .adc_data(adc_data),
        .adc_clk(adc_clk), .adc_oe(adc_oe)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // cycle id stays stable across each rising edge
    always @(negedge clk) begin
        cyc++;
    end

    always @(posedge clk) begin
        if (cyc > CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    // steep noisy ramp for the ADC with a new value on each falling adc_clk
    always @(negedge adc_clk) begin
        ramp = ramp + 60 + int'($urandom % 41);
        if (ramp > 3100) begin
            ramp = int'($urandom % 200);
        end
        adc_data <= 12'(ramp + int'($urandom % 8));
    end

    always @(posedge adc_clk) begin
        tick_cyc.push_back(cyc);
        tick_val.push_back(adc_data);
    end

    always @(negedge notify) begin
        fall_cyc = cyc;
    end

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // region on the rise of en, data on its fall
    task automatic bus_write(input reg_region_e region, input logic [15:0] data);
        @(posedge clk);
        en        <= 1'b1;
        module_in <= {region, 13'd0};
        @(posedge clk);
        en        <= 1'b0;
        module_in <= data;
        @(posedge clk);
    endtask

    task automatic bus_start(output int issued);
        @(posedge clk);
        issued = cyc;
        en        <= 1'b1;
        module_in <= {REG_START, 13'd0};
        @(posedge clk);
        en <= 1'b0;
    endtask

    task automatic read_buffer(input int addr, output int data);
        @(posedge clk);
        en        <= 1'b1;
        module_in <= {REG_BUF_READ, 4'd0, 9'(addr)};
        @(posedge clk);
        en <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        data = module_out;
    endtask

    task automatic wait_ticks(input int needed);
        while (tick_cyc.size() < needed) begin
            @(negedge clk);
        end
    endtask

    // P periods with num M over den P must last P*N+M clocks
    task automatic test_divider(input int n, input int p, input int m);
        int first;
        bus_write(REG_DIV_INT, 16'(n));
        bus_write(REG_DIV_FRAC, {8'(p), 8'(m)});
        first = tick_cyc.size() + 3;
        wait_ticks(first + p + 1);
        check_value("adc_clk period sum", tick_cyc[first + p] - tick_cyc[first], p * n + m);
    endtask

    task automatic run_capture(input int n, input int thresh, input bit extra_start);
        int issued;
        int ignored;
        int den;
        int first;
        int trig;
        int prev;
        int v;
        int got;
        int low_cycles;
        bit hit;
        den = 2 + int'($urandom % 14);
        bus_write(REG_DIV_INT, 16'(n));
        bus_write(REG_DIV_FRAC, {8'(den), 8'($urandom % den)});
        bus_write(REG_THRESH, 16'(thresh));
        bus_start(issued);
        @(negedge clk);
        check_value("notify", notify, 0);
        @(negedge clk);
        check_value("notify", notify, 1);
        check_value("adc_oe", adc_oe, 0);
        check_value("read_adc_result", read_adc_result, 1);
        if (extra_start) begin
            repeat (100 * n) @(negedge clk);
            check_value("notify", notify, 1);
            bus_start(ignored);
        end
        low_cycles = 0;
        @(negedge clk);
        while (notify) begin
            check_value("adc_oe", adc_oe, 0);
            if (!read_adc_result) begin
                low_cycles++;
            end
            @(negedge clk);
        end
        check_value("adc_oe", adc_oe, 1);
        // reference model over the armed ticks from the clock after start
        first = 0;
        while (tick_cyc[first] < issued + 2) begin
            first++;
        end
        prev = 0;
        trig = -1;
        hit = 1'b0;
        for (int i = 0; i < `ADC_TRIG_TIMEOUT && trig < 0; i++) begin
            v = tick_val[first + i];
            if (v + `ADC_TRIG_WIN_LO >= thresh && v <= thresh + `ADC_TRIG_WIN_HI
                    && v > prev + `ADC_TRIG_SLOPE) begin
                trig = first + i;
                hit = 1'b1;
            end else if (i == `ADC_TRIG_TIMEOUT - 1) begin
                trig = first + i;
            end
            prev = v;
        end
        check_value("read_adc_result", read_adc_result, hit);
        if (hit) begin
            check_value("read_adc_result low cycles", low_cycles, 0);
        end
        check_value("notify fall cycle", fall_cyc, tick_cyc[trig + `ADC_SAMPLE_DEPTH] + 2);
        for (int addr = 0; addr < `ADC_SAMPLE_DEPTH; addr++) begin
            read_buffer(addr, got);
            check_value($sformatf("module_out[%0d]", addr), got, tick_val[trig + 1 + addr]);
        end
        check_value("notify", notify, 0);
    endtask

    initial begin
        int n;
        int p;
        void'($urandom(77860));
        reset     = 1'b0;
        en        = 1'b0;
        module_in = '0;
        adc_data  = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_value("notify", notify, 0);
        check_value("read_adc_result", read_adc_result, 0);
        check_value("adc_oe", adc_oe, 1);
        // divider stays idle while div_int is zero
        repeat (50) begin
            @(negedge clk);
            check_value("adc_clk", adc_clk, 0);
        end
        check_value("adc_clk rises", tick_cyc.size(), 0);
        repeat (DIV_TESTS) begin
            n = 2 + int'($urandom % 8);
            p = 2 + int'($urandom % 14);
            test_divider(n, p, int'($urandom % p));
        end
        run_capture(2 + int'($urandom % 8), 1000 + int'($urandom % 1500), 1'b0);
        // threshold above anything the ramp reaches
        run_capture(2 + int'($urandom % 8), 4000, 1'b0);
        run_capture(2 + int'($urandom % 8), 1000 + int'($urandom % 1500), 1'b1);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+hw
hw/adc_capture_pkg.sv
hw/frac_clock_divider.sv
hw/capture_regs.sv
hw/trigger_detect.sv
hw/capture_sequencer.sv
hw/sample_buffer.sv
hw/frequency_measure.sv
dv/tb_frequency_measure.sv

// File: Makefile
# Verilator build and run of the ADC capture testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_frequency_measure --Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim

clean:
	rm -rf obj_dir
